// File: hdl/cdb_arbiter.sv
//////////////////////////////////////////////////
// CDB arbiter
// Round-robin pick of one finished station and
// registered broadcast of its result
//////////////////////////////////////////////////

module cdb_arbiter import ooo_pkg::*; #(
    parameter int NUM_RS = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic        [NUM_RS-1:0] done,
    input  cdb_t        [NUM_RS-1:0] results,
    output logic        [NUM_RS-1:0] grant,
    output cdb_t                     cdb
);

    localparam int IDX_W = (NUM_RS > 1) ? $clog2(NUM_RS) : 1;

    logic [IDX_W-1:0] last_win;
    logic [IDX_W-1:0] win;
    logic             found;

    // Search starts one past the last winner
    always_comb begin
        int idx;
        grant = '0;
        win   = last_win;
        found = 1'b0;
        for (int i = 1; i <= NUM_RS; i++) begin
            idx = (int'(last_win) + i) % NUM_RS;
            if (!found && done[idx]) begin
                grant[idx] = 1'b1;
                win        = IDX_W'(idx);
                found      = 1'b1;
            end
        end
    end

    // Bus is valid the cycle after the grant
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Station 0 first after reset
            last_win <= IDX_W'(NUM_RS - 1);
            cdb      <= '0;
        end else begin
            cdb <= '{valid: found, tag: results[win].tag, value: results[win].value};
            if (found) begin
                last_win <= win;
            end
        end
    end

endmodule

// File: hdl/dispatch_unit.sv
//////////////////////////////////////////////////
// Dispatch unit
// Instruction queue, map table, architectural
// register file and reservation station selection
//////////////////////////////////////////////////

module dispatch_unit import ooo_pkg::*; #(
    parameter int NUM_RS   = 4,
    parameter int IQ_DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              inst_valid,
    input  inst_t             inst,
    input  logic [NUM_RS-1:0] rs_free,
    input  logic              rob_full,
    input  rob_tag_t          alloc_tag,
    input  logic [1:0]        lookup_done,
    input  word_t [1:0]       lookup_value,
    input  cdb_t              cdb,
    input  retire_t           retire,
    output logic              iq_full,
    output logic [NUM_RS-1:0] rs_issue_strobe,
    output rs_issue_t         rs_issue,
    output logic              alloc_valid,
    output reg_idx_t          alloc_rd,
    output rob_tag_t [1:0]    lookup_tag
);

    localparam int PTR_W = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_W = $clog2(IQ_DEPTH + 1);
    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(IQ_DEPTH - 1);

    inst_t             iq_mem [IQ_DEPTH];
    logic [PTR_W-1:0]  iq_rd_ptr;
    logic [PTR_W-1:0]  iq_wr_ptr;
    logic [CNT_W-1:0]  iq_count;
    inst_t             head;
    logic              push;
    logic              dispatch;
    logic [NUM_RS-1:0] rs_sel;
    reg_idx_t [1:0]    src_reg;
    operand_t [1:0]    src_op;
    word_t             regfile [32];
    logic [31:0]       map_busy;
    rob_tag_t          map_tag [32];

    //////////////////////////////////////////////////
    // Instruction queue
    //////////////////////////////////////////////////

    // Strobe while full is dropped
    assign push    = inst_valid && !iq_full;
    assign iq_full = (iq_count == CNT_W'(IQ_DEPTH));
    assign head    = iq_mem[iq_rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            iq_rd_ptr <= '0;
            iq_wr_ptr <= '0;
            iq_count  <= '0;
        end else begin
            if (push) begin
                iq_wr_ptr <= (iq_wr_ptr == PTR_LAST) ? '0 : iq_wr_ptr + 1'b1;
            end
            if (dispatch) begin
                iq_rd_ptr <= (iq_rd_ptr == PTR_LAST) ? '0 : iq_rd_ptr + 1'b1;
            end
            iq_count <= iq_count + CNT_W'(push) - CNT_W'(dispatch);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            iq_mem[iq_wr_ptr] <= inst;
        end
    end

    //////////////////////////////////////////////////
    // Dispatch and operand resolution
    //////////////////////////////////////////////////

    // Lowest free station by isolating the lowest set bit
    assign rs_sel   = rs_free & (~rs_free + NUM_RS'(1));
    assign dispatch = (iq_count != '0) && (|rs_free) && !rob_full;

    assign rs_issue_strobe = dispatch ? rs_sel : '0;
    assign alloc_valid     = dispatch;
    assign alloc_rd        = head.rd;
    assign src_reg         = {head.rs2, head.rs1};

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup_tag[i]   = map_tag[src_reg[i]];
            src_op[i].tag   = map_tag[src_reg[i]];
            src_op[i].ready = 1'b1;
            if (head.op == OP_LI) begin
                // Sources ignored for an immediate load
                src_op[i].value = '0;
            end else if (src_reg[i] == '0 || !map_busy[src_reg[i]]) begin
                src_op[i].value = regfile[src_reg[i]];
            end else if (lookup_done[i]) begin
                src_op[i].value = lookup_value[i];
            end else if (cdb.valid && cdb.tag == src_op[i].tag) begin
                // Producer broadcasting right now
                src_op[i].value = cdb.value;
            end else begin
                src_op[i].ready = 1'b0;
                src_op[i].value = '0;
            end
        end
    end

    assign rs_issue = '{
        op:   head.op,
        tag:  alloc_tag,
        src1: src_op[0],
        src2: src_op[1],
        imm:  head.imm
    };

    //////////////////////////////////////////////////
    // Register file and map table
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            map_busy <= '0;
            for (int r = 0; r < 32; r++) begin
                regfile[r] <= '0;
            end
        end else begin
            if (retire.valid && retire.rd != '0) begin
                regfile[retire.rd] <= retire.value;
                // Clear only if no younger writer
                if (map_tag[retire.rd] == retire.tag) begin
                    map_busy[retire.rd] <= 1'b0;
                end
            end
            // Rename comes after retire and wins
            if (dispatch && head.rd != '0) begin
                map_busy[head.rd] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch && head.rd != '0) begin
            map_tag[head.rd] <= alloc_tag;
        end
    end

endmodule

// File: hdl/ooo_core.sv
//////////////////////////////////////////////////
// Out-of-order core slice top level
// Dispatch, reservation stations, CDB arbiter and
// reorder buffer with in-order commit
//////////////////////////////////////////////////

module ooo_core import ooo_pkg::*; #(
    parameter int NUM_RS     = 4,
    parameter int MUL_CYCLES = 4,
    parameter int IQ_DEPTH   = 4
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     inst_valid,
    input  inst_t    inst,
    output logic     iq_full,
    output logic     commit_valid,
    output reg_idx_t commit_rd,
    output word_t    commit_data
);

    //////////////////////////////////////////////////
    // Interconnect
    //////////////////////////////////////////////////

    // Dispatch and stations
    logic [NUM_RS-1:0] rs_free;
    logic [NUM_RS-1:0] rs_issue_strobe;
    rs_issue_t         rs_issue;

    // Stations and arbiter
    logic [NUM_RS-1:0] rs_done;
    logic [NUM_RS-1:0] rs_grant;
    cdb_t [NUM_RS-1:0] rs_result;
    cdb_t              cdb;

    // Dispatch and ROB
    logic              alloc_valid;
    reg_idx_t          alloc_rd;
    rob_tag_t          alloc_tag;
    logic              rob_full;
    rob_tag_t [1:0]    lookup_tag;
    logic [1:0]        lookup_done;
    word_t [1:0]       lookup_value;
    retire_t           retire;

    dispatch_unit #(
        .NUM_RS   (NUM_RS),
        .IQ_DEPTH (IQ_DEPTH)
    ) u_dispatch_unit (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .rs_free         (rs_free),
        .rob_full        (rob_full),
        .alloc_tag       (alloc_tag),
        .lookup_done     (lookup_done),
        .lookup_value    (lookup_value),
        .cdb             (cdb),
        .retire          (retire),
        .iq_full         (iq_full),
        .rs_issue_strobe (rs_issue_strobe),
        .rs_issue        (rs_issue),
        .alloc_valid     (alloc_valid),
        .alloc_rd        (alloc_rd),
        .lookup_tag      (lookup_tag)
    );

    // Station array with one strobe and grant bit each
    for (genvar g = 0; g < NUM_RS; g++) begin : g_rs
        res_station #(
            .MUL_CYCLES (MUL_CYCLES)
        ) u_res_station (
            .clk          (clk),
            .rst_n        (rst_n),
            .issue_strobe (rs_issue_strobe[g]),
            .issue        (rs_issue),
            .cdb          (cdb),
            .grant        (rs_grant[g]),
            .free         (rs_free[g]),
            .done         (rs_done[g]),
            .result       (rs_result[g])
        );
    end

    cdb_arbiter #(
        .NUM_RS (NUM_RS)
    ) u_cdb_arbiter (
        .clk     (clk),
        .rst_n   (rst_n),
        .done    (rs_done),
        .results (rs_result),
        .grant   (rs_grant),
        .cdb     (cdb)
    );

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .rst_n        (rst_n),
        .alloc_valid  (alloc_valid),
        .alloc_rd     (alloc_rd),
        .lookup_tag   (lookup_tag),
        .cdb          (cdb),
        .alloc_tag    (alloc_tag),
        .rob_full     (rob_full),
        .lookup_done  (lookup_done),
        .lookup_value (lookup_value),
        .retire       (retire)
    );

    // Commit ports follow retire
    assign commit_valid = retire.valid;
    assign commit_rd    = retire.rd;
    assign commit_data  = retire.value;

endmodule

// File: hdl/ooo_pkg.sv
//////////////////////////////////////////////////
// Out-of-order core slice shared definitions
// Data widths, ROB tag sizing, opcodes, station
// states and the packets passed between blocks
//////////////////////////////////////////////////

package ooo_pkg;

    // ROB sizing, tag width sets the depth
    localparam int ROB_TAG_W = 3;
    localparam int ROB_DEPTH = 1 << ROB_TAG_W;

    // Plain vector types
    typedef logic [31:0]          word_t;
    typedef logic [4:0]           reg_idx_t;
    typedef logic [ROB_TAG_W-1:0] rob_tag_t;

    // Integer operations
    typedef enum logic [2:0] {
        OP_LI,
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_MUL
    } alu_op_e;

    // Reservation station FSM
    typedef enum logic [1:0] {
        RS_IDLE,
        RS_WAIT,
        RS_EXEC,
        RS_DONE
    } rs_state_e;

    //////////////////////////////////////////////////
    // Packets
    //////////////////////////////////////////////////

    // Decoded instruction from the source
    typedef struct packed {
        alu_op_e  op;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
    } inst_t;

    // One source operand, value or pending tag
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    // Dispatch to station
    typedef struct packed {
        alu_op_e  op;
        rob_tag_t tag;
        operand_t src1;
        operand_t src2;
        word_t    imm;
    } rs_issue_t;

    // Common data bus broadcast
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // Oldest completed ROB entry
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        reg_idx_t rd;
        word_t    value;
    } retire_t;

endpackage

// File: hdl/reorder_buffer.sv
//////////////////////////////////////////////////
// Reorder buffer
// Circular buffer of in-flight results, operand
// lookups for dispatch, in-order retire
//////////////////////////////////////////////////

module reorder_buffer import ooo_pkg::*; (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           alloc_valid,
    input  reg_idx_t       alloc_rd,
    input  rob_tag_t [1:0] lookup_tag,
    input  cdb_t           cdb,
    output rob_tag_t       alloc_tag,
    output logic           rob_full,
    output logic [1:0]     lookup_done,
    output word_t [1:0]    lookup_value,
    output retire_t        retire
);

    localparam int CNT_W = ROB_TAG_W + 1;

    reg_idx_t             ent_rd    [ROB_DEPTH];
    word_t                ent_value [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] ent_done;
    rob_tag_t             head;
    rob_tag_t             tail;
    logic [CNT_W-1:0]     count;
    logic                 head_cdb;
    logic                 head_ready;
    word_t                head_value;

    assign alloc_tag = tail;
    // Count MSB is set only when every entry is in use
    assign rob_full  = count[ROB_TAG_W];

    //////////////////////////////////////////////////
    // Operand lookups
    //////////////////////////////////////////////////

    // Done flag survives retire until reallocated
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            lookup_done[i]  = ent_done[lookup_tag[i]];
            lookup_value[i] = ent_value[lookup_tag[i]];
        end
    end

    //////////////////////////////////////////////////
    // Head completion and retire
    //////////////////////////////////////////////////

    // Head completes in its CDB cycle
    assign head_cdb   = cdb.valid && (cdb.tag == head);
    assign head_ready = (count != '0) && (ent_done[head] || head_cdb);
    assign head_value = ent_done[head] ? ent_value[head] : cdb.value;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head     <= '0;
            tail     <= '0;
            count    <= '0;
            ent_done <= '0;
            retire   <= '0;
        end else begin
            if (alloc_valid) begin
                tail           <= tail + 1'b1;
                ent_done[tail] <= 1'b0;
            end
            // Mark complete from the broadcast
            if (cdb.valid) begin
                ent_done[cdb.tag] <= 1'b1;
            end
            if (head_ready) begin
                head <= head + 1'b1;
            end
            count  <= count + CNT_W'(alloc_valid) - CNT_W'(head_ready);
            retire <= '{
                valid: head_ready,
                tag:   head,
                rd:    ent_rd[head],
                value: head_value
            };
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            ent_rd[tail] <= alloc_rd;
        end
        if (cdb.valid) begin
            ent_value[cdb.tag] <= cdb.value;
        end
    end

endmodule

// File: hdl/res_station.sv
//////////////////////////////////////////////////
// Reservation station
// Holds one instruction, snoops the CDB for its
// operands and runs its own execution unit
//////////////////////////////////////////////////

module res_station import ooo_pkg::*; #(
    parameter int MUL_CYCLES = 4
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      issue_strobe,
    input  rs_issue_t issue,
    input  cdb_t      cdb,
    input  logic      grant,
    output logic      free,
    output logic      done,
    output cdb_t      result
);

    localparam int CNT_W = $clog2(MUL_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(MUL_CYCLES - 1);

    rs_state_e        state;
    rs_issue_t        entry;
    logic [CNT_W-1:0] mul_cnt;
    word_t            alu_out;
    word_t            res_value;

    // Capture a pending operand off the bus
    function automatic operand_t snoop(operand_t src, cdb_t bus);
        operand_t upd;
        upd = src;
        if (!src.ready && bus.valid && bus.tag == src.tag) begin
            upd.ready = 1'b1;
            upd.value = bus.value;
        end
        return upd;
    endfunction

    //////////////////////////////////////////////////
    // Station FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= RS_IDLE;
            mul_cnt <= '0;
        end else begin
            mul_cnt <= (state == RS_EXEC) ? mul_cnt + 1'b1 : '0;
            case (state)
                RS_IDLE: if (issue_strobe) state <= RS_WAIT;
                RS_WAIT: if (entry.src1.ready && entry.src2.ready) state <= RS_EXEC;
                // Multiply holds EXEC for MUL_CYCLES
                RS_EXEC: if (entry.op != OP_MUL || mul_cnt == CNT_LAST) state <= RS_DONE;
                // Hold result until the arbiter picks us
                RS_DONE: if (grant) state <= RS_IDLE;
                default: state <= RS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RS_IDLE && issue_strobe) begin
            entry <= issue;
        end else begin
            entry.src1 <= snoop(entry.src1, cdb);
            entry.src2 <= snoop(entry.src2, cdb);
        end
        if (state == RS_EXEC) begin
            res_value <= alu_out;
        end
    end

    //////////////////////////////////////////////////
    // Execution unit
    //////////////////////////////////////////////////

    always_comb begin
        case (entry.op)
            OP_LI:   alu_out = entry.imm;
            OP_ADD:  alu_out = entry.src1.value + entry.src2.value;
            OP_SUB:  alu_out = entry.src1.value - entry.src2.value;
            OP_AND:  alu_out = entry.src1.value & entry.src2.value;
            OP_OR:   alu_out = entry.src1.value | entry.src2.value;
            OP_XOR:  alu_out = entry.src1.value ^ entry.src2.value;
            // Low 32 bits kept
            OP_MUL:  alu_out = entry.src1.value * entry.src2.value;
            default: alu_out = '0;
        endcase
    end

    assign free   = (state == RS_IDLE);
    assign done   = (state == RS_DONE);
    assign result = '{valid: done, tag: entry.tag, value: res_value};

endmodule

// File: list.f
hdl/ooo_pkg.sv
hdl/dispatch_unit.sv
hdl/res_station.sv
hdl/cdb_arbiter.sv
hdl/reorder_buffer.sv
hdl/ooo_core.sv
sim/ooo_core_tb.sv

// File: sim/ooo_core_patterns.txt
# op rd rs1 rs2 imm exp_rd exp_data, all hex
# op codes: 0 li, 1 add, 2 sub, 3 and, 4 or, 5 xor, 6 mul
0 01 00 00 00000005 01 00000005
0 02 00 00 00000003 02 00000003
0 03 00 00 0000f0f0 03 0000f0f0
1 04 01 02 00000000 04 00000008
2 05 01 02 00000000 05 00000002
4 06 03 01 00000000 06 0000f0f5
5 07 03 02 00000000 07 0000f0f3
3 08 06 07 00000000 08 0000f0f1
1 09 04 05 00000000 09 0000000a
1 0a 09 09 00000000 0a 00000014
2 0b 0a 01 00000000 0b 0000000f
5 0c 0b 0a 00000000 0c 0000001b
0 0d 00 00 00001234 0d 00001234
6 0e 0d 0d 00000000 0e 014b5a90
0 0f 00 00 00000077 0f 00000077
4 10 01 02 00000000 10 00000007
2 11 02 01 00000000 11 fffffffe
1 12 0e 11 00000000 12 014b5a8e
0 14 00 00 00000011 14 00000011
0 14 00 00 00000022 14 00000022
1 14 14 14 00000000 14 00000044
1 15 14 01 00000000 15 00000049
0 00 00 00 0000abcd 00 0000abcd
1 16 00 01 00000000 16 00000005
5 00 01 02 00000000 00 00000006
4 17 00 00 00000000 17 00000000
0 18 00 00 00000003 18 00000003
6 19 18 18 00000000 19 00000009
6 1a 19 18 00000000 1a 0000001b
6 1b 1a 19 00000000 1b 000000f3
6 1c 1b 1a 00000000 1c 000019a1
1 1d 1c 01 00000000 1d 000019a6
2 1e 1d 1c 00000000 1e 00000005
6 1f 1c 1c 00000000 1f 0290d741
5 18 1f 1e 00000000 18 0290d744
1 19 18 1a 00000000 19 0290d75f
0 1a 00 00 deadbeef 1a deadbeef
3 1b 1a 19 00000000 1b 0280964f

// File: sim/ooo_core_tb.sv
//////////////////////////////////////////////////
// Out-of-order core slice testbench
// Reads instruction patterns, strobes them in with
// random gaps and checks each commit in order
//////////////////////////////////////////////////

module ooo_core_tb import ooo_pkg::*; ();

    // Trailing patterns sent back to back
    localparam int    BURST_LEN = 12;
    localparam string PAT_FILE  = "sim/ooo_core_patterns.txt";

    logic        clk;
    logic        rst_n;
    logic        inst_valid;
    inst_t       inst;
    logic        iq_full;
    logic        commit_valid;
    reg_idx_t    commit_rd;
    word_t       commit_data;

    // Pattern storage
    inst_t       pat_inst [$];
    reg_idx_t    exp_rd   [$];
    word_t       exp_data [$];
    int          num_pat;
    int          commit_idx;
    int          cycle_cnt;
    int          cycle_limit;
    logic        saw_full;
    int unsigned lcg_state;

    ooo_core i_ooo_core (
        .clk          (clk),
        .rst_n        (rst_n),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .iq_full      (iq_full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    // LCG step returning the upper bits
    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state >> 16) & 32'h7fff;
    endfunction

    task automatic check_value(input word_t actual, input word_t expected, input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("SIMULATION FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic load_patterns();
        int    fd;
        int    n;
        int    f_op;
        int    f_rd;
        int    f_rs1;
        int    f_rs2;
        int    f_erd;
        word_t f_imm;
        word_t f_data;
        string line;
        inst_t ins;
        fd = $fopen(PAT_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open pattern file %s", PAT_FILE);
            $display("SIMULATION FAILED");
            $fatal(1, "missing pattern file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // Skip comment and blank lines
            if (n > 0 && line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_op, f_rd, f_rs1, f_rs2, f_imm, f_erd, f_data);
                if (n != 7) begin
                    $display("Malformed pattern line: %s", line);
                    $display("SIMULATION FAILED");
                    $fatal(1, "bad pattern file");
                end
                ins.op  = alu_op_e'(f_op[2:0]);
                ins.rd  = f_rd[4:0];
                ins.rs1 = f_rs1[4:0];
                ins.rs2 = f_rs2[4:0];
                ins.imm = f_imm;
                pat_inst.push_back(ins);
                exp_rd.push_back(f_erd[4:0]);
                exp_data.push_back(f_data);
            end
        end
        $fclose(fd);
        num_pat = pat_inst.size();
        if (num_pat == 0) begin
            $display("Pattern file holds no instructions");
            $display("SIMULATION FAILED");
            $fatal(1, "empty pattern file");
        end
    endtask

    // One strobe per falling edge and none while the queue is full
    task automatic send_all();
        int gap;
        for (int i = 0; i < num_pat; i++) begin
            gap = (i < num_pat - BURST_LEN) ? int'(next_rand() % 4) : 0;
            repeat (gap) begin
                @(negedge clk);
                inst_valid = 1'b0;
            end
            @(negedge clk);
            while (iq_full) begin
                saw_full   = 1'b1;
                inst_valid = 1'b0;
                @(negedge clk);
            end
            inst_valid = 1'b1;
            inst       = pat_inst[i];
        end
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Commit monitor and timeout
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        if (commit_valid === 1'b1) begin
            if (commit_idx >= num_pat) begin
                $display("Commit at time %0t has no pattern left to match", $time);
                $display("SIMULATION FAILED");
                $fatal(1, "extra commit");
            end else begin
                check_value(word_t'(commit_rd), word_t'(exp_rd[commit_idx]),
                            $sformatf("rd of commit %0d", commit_idx));
                check_value(commit_data, exp_data[commit_idx],
                            $sformatf("data of commit %0d", commit_idx));
                commit_idx++;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt++;
            if (cycle_cnt > cycle_limit) begin
                $display("Timeout after %0d cycles, commits did not finish (%0d of %0d)",
                         cycle_cnt, commit_idx, num_pat);
                $display("SIMULATION FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        inst_valid = 1'b0;
        inst       = '0;
        rst_n      = 1'b0;
        saw_full   = 1'b0;
        commit_idx = 0;
        cycle_cnt  = 0;
        lcg_state  = 32'd83;
        load_patterns();
        cycle_limit = 30 * num_pat + 100;
        repeat (16) @(negedge clk);
        // Outputs idle once reset has taken effect
        check_value(word_t'(iq_full), 32'd0, "iq_full after reset");
        check_value(word_t'(commit_valid), 32'd0, "commit_valid after reset");
        rst_n = 1'b1;
        send_all();
        wait (commit_idx == num_pat);
        // Idle tail to catch stray commits
        repeat (20) @(negedge clk);
        check_value(word_t'(saw_full), 32'd1, "iq_full seen during burst");
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule
